// File: verilog/vram_pkg.sv
`default_nettype none

package vram_pkg;

	// requester side address and data
	localparam int addr_w = 16;
	localparam int data_w = 16;

	// bank geometry, 4 banks of 16K words
	localparam int bank_addr_w = 14;
	localparam int bank_sel_w = addr_w - bank_addr_w;
	localparam int num_banks = 4;
	localparam int bank_depth = 1 << bank_addr_w;

	// bank state and grant owner
	// idle means the bank is free to arbitrate this cycle
	typedef enum logic [2:0] {
		req_idle,
		req_sprite,
		req_bg,
		req_flash,
		req_cpu
	} req_id_t;

	// access type presented to a bank
	typedef enum logic {
		op_read,
		op_write
	} mem_op_t;

endpackage

`default_nettype wire

// File: verilog/bank_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bank_decode import vram_pkg::*;
(
	input  wire logic [addr_w-1:0]    sprite_addr,
	input  wire logic [addr_w-1:0]    bg_addr,
	input  wire logic [addr_w-1:0]    flash_addr,
	input  wire logic [addr_w-1:0]    cpu_addr,

	input  wire logic                 sprite_valid,
	input  wire logic                 bg_valid,
	input  wire logic                 flash_valid,
	input  wire logic                 cpu_valid,

	output logic [num_banks-1:0]      sprite_bank_req,
	output logic [num_banks-1:0]      bg_bank_req,
	output logic [num_banks-1:0]      flash_bank_req,
	output logic [num_banks-1:0]      cpu_bank_req
);

	// one-hot bank select from the top address bits
	function automatic logic [num_banks-1:0] bank_hit(
		input logic              valid,
		input logic [addr_w-1:0] addr
	);
		logic [num_banks-1:0] hit;
		hit = '0;
		if (valid) begin
			hit[addr[addr_w-1 -: bank_sel_w]] = 1'b1;
		end
		return hit;
	endfunction

	// each arbiter only looks at its own column
	assign sprite_bank_req = bank_hit(sprite_valid, sprite_addr);
	assign bg_bank_req     = bank_hit(bg_valid, bg_addr);
	assign flash_bank_req  = bank_hit(flash_valid, flash_addr);
	assign cpu_bank_req    = bank_hit(cpu_valid, cpu_addr);

endmodule

`default_nettype wire

// File: verilog/bank_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter import vram_pkg::*;
(
	input  wire logic                    CLK,
	input  wire logic                    RSTb,

	input  wire logic                    sprite_req,
	input  wire logic                    bg_req,
	input  wire logic                    flash_req,
	input  wire logic                    cpu_req,

	input  wire logic [bank_addr_w-1:0]  sprite_offset,
	input  wire logic [bank_addr_w-1:0]  bg_offset,
	input  wire logic [bank_addr_w-1:0]  flash_offset,
	input  wire logic [bank_addr_w-1:0]  cpu_offset,

	input  wire logic [data_w-1:0]       flash_wdata,
	input  wire logic [data_w-1:0]       cpu_wdata,
	input  wire logic                    cpu_wr,

	// winner of this cycle, owns the bank from the next edge
	output req_id_t                      grant,
	output logic [bank_addr_w-1:0]       ram_addr,
	output logic [data_w-1:0]            ram_wdata,
	output logic                         ram_we
);

	req_id_t state;
	req_id_t winner;
	mem_op_t op;

	// fixed priority, only while the bank is free
	always_comb begin
		winner = req_idle;
		if (state == req_idle) begin
			if (sprite_req) begin
				winner = req_sprite;
			end else if (bg_req) begin
				winner = req_bg;
			end else if (flash_req) begin
				winner = req_flash;
			end else if (cpu_req) begin
				winner = req_cpu;
			end
		end
	end

	// steer the winner onto the bank port
	always_comb begin
		ram_addr  = '0;
		ram_wdata = '0;
		op        = op_read;
		case (winner)
			req_sprite: begin
				ram_addr = sprite_offset;
			end
			req_bg: begin
				ram_addr = bg_offset;
			end
			req_flash: begin
				// flash loader only ever writes
				ram_addr  = flash_offset;
				ram_wdata = flash_wdata;
				op        = op_write;
			end
			req_cpu: begin
				ram_addr  = cpu_offset;
				ram_wdata = cpu_wdata;
				op        = cpu_wr ? op_write : op_read;
			end
			default: ;
		endcase
	end

	assign ram_we = (op == op_write);
	assign grant  = winner;

	// granted for one cycle, then back to idle
	// winner is req_idle whenever the bank is busy
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= req_idle;
		end else begin
			state <= winner;
		end
	end

endmodule

`default_nettype wire

// File: verilog/bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bank_ram import vram_pkg::*;
(
	input  wire logic                    CLK,
	input  wire logic [bank_addr_w-1:0]  ram_addr,
	input  wire logic [data_w-1:0]       ram_wdata,
	input  wire logic                    ram_we,
	output logic [data_w-1:0]            ram_rdata
);

	logic [data_w-1:0] mem [bank_depth];

	// registered read, old data on a write cycle
	always_ff @(posedge CLK) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
		end
		ram_rdata <= mem[ram_addr];
	end

endmodule

`default_nettype wire

// File: verilog/read_return.sv
`timescale 1ns/1ps
`default_nettype none

module read_return import vram_pkg::*;
(
	input  wire logic               CLK,
	input  wire logic               RSTb,

	input  req_id_t                 grant0,
	input  req_id_t                 grant1,
	input  req_id_t                 grant2,
	input  req_id_t                 grant3,

	input  wire logic [data_w-1:0]  rdata0,
	input  wire logic [data_w-1:0]  rdata1,
	input  wire logic [data_w-1:0]  rdata2,
	input  wire logic [data_w-1:0]  rdata3,

	output logic                    sprite_ready,
	output logic                    bg_ready,
	output logic                    flash_ready,
	output logic                    cpu_ready,
	output logic [data_w-1:0]       sprite_rdata,
	output logic [data_w-1:0]       bg_rdata,
	output logic [data_w-1:0]       cpu_rdata
);

	req_id_t           owner [num_banks];
	logic [data_w-1:0] rdata_bank [num_banks];

	assign rdata_bank[0] = rdata0;
	assign rdata_bank[1] = rdata1;
	assign rdata_bank[2] = rdata2;
	assign rdata_bank[3] = rdata3;

	// owner lines up with the cycle the ram data is valid
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			owner[0] <= req_idle;
			owner[1] <= req_idle;
			owner[2] <= req_idle;
			owner[3] <= req_idle;
		end else begin
			owner[0] <= grant0;
			owner[1] <= grant1;
			owner[2] <= grant2;
			owner[3] <= grant3;
		end
	end

	// a requester owns at most one bank, so no two banks collide here
	always_comb begin
		sprite_ready = 1'b0;
		bg_ready     = 1'b0;
		flash_ready  = 1'b0;
		cpu_ready    = 1'b0;
		sprite_rdata = '0;
		bg_rdata     = '0;
		cpu_rdata    = '0;
		for (int b = 0; b < num_banks; b++) begin
			case (owner[b])
				req_sprite: begin
					sprite_ready = 1'b1;
					sprite_rdata = rdata_bank[b];
				end
				req_bg: begin
					bg_ready = 1'b1;
					bg_rdata = rdata_bank[b];
				end
				req_flash: begin
					// write completion only
					flash_ready = 1'b1;
				end
				req_cpu: begin
					cpu_ready = 1'b1;
					cpu_rdata = rdata_bank[b];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/memory_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter import vram_pkg::*;
(
	input  wire logic               CLK,
	input  wire logic               RSTb,

	// sprite engine, read only
	input  wire logic [addr_w-1:0]  sprite_addr,
	input  wire logic               sprite_valid,
	output logic                    sprite_ready,
	output logic [data_w-1:0]       sprite_rdata,

	// background engine, read only
	input  wire logic [addr_w-1:0]  bg_addr,
	input  wire logic               bg_valid,
	output logic                    bg_ready,
	output logic [data_w-1:0]       bg_rdata,

	// flash loader, write only
	input  wire logic [addr_w-1:0]  flash_addr,
	input  wire logic [data_w-1:0]  flash_wdata,
	input  wire logic               flash_valid,
	output logic                    flash_ready,

	// cpu, read or write
	input  wire logic [addr_w-1:0]  cpu_addr,
	input  wire logic [data_w-1:0]  cpu_wdata,
	input  wire logic               cpu_wr,
	input  wire logic               cpu_valid,
	output logic                    cpu_ready,
	output logic [data_w-1:0]       cpu_rdata
);

	logic [num_banks-1:0]   sprite_bank_req;
	logic [num_banks-1:0]   bg_bank_req;
	logic [num_banks-1:0]   flash_bank_req;
	logic [num_banks-1:0]   cpu_bank_req;

	req_id_t                grant [num_banks];
	logic [bank_addr_w-1:0] ram_addr [num_banks];
	logic [data_w-1:0]      ram_wdata [num_banks];
	logic                   ram_we [num_banks];
	logic [data_w-1:0]      ram_rdata [num_banks];

	bank_decode u_decode (
		.sprite_addr     (sprite_addr),
		.bg_addr         (bg_addr),
		.flash_addr      (flash_addr),
		.cpu_addr        (cpu_addr),
		.sprite_valid    (sprite_valid),
		.bg_valid        (bg_valid),
		.flash_valid     (flash_valid),
		.cpu_valid       (cpu_valid),
		.sprite_bank_req (sprite_bank_req),
		.bg_bank_req     (bg_bank_req),
		.flash_bank_req  (flash_bank_req),
		.cpu_bank_req    (cpu_bank_req)
	);

	// one arbiter and one ram per bank, all running in parallel
	for (genvar b = 0; b < num_banks; b++) begin : g_bank
		bank_arbiter u_arb (
			.CLK           (CLK),
			.RSTb          (RSTb),
			.sprite_req    (sprite_bank_req[b]),
			.bg_req        (bg_bank_req[b]),
			.flash_req     (flash_bank_req[b]),
			.cpu_req       (cpu_bank_req[b]),
			.sprite_offset (sprite_addr[bank_addr_w-1:0]),
			.bg_offset     (bg_addr[bank_addr_w-1:0]),
			.flash_offset  (flash_addr[bank_addr_w-1:0]),
			.cpu_offset    (cpu_addr[bank_addr_w-1:0]),
			.flash_wdata   (flash_wdata),
			.cpu_wdata     (cpu_wdata),
			.cpu_wr        (cpu_wr),
			.grant         (grant[b]),
			.ram_addr      (ram_addr[b]),
			.ram_wdata     (ram_wdata[b]),
			.ram_we        (ram_we[b])
		);

		bank_ram u_ram (
			.CLK       (CLK),
			.ram_addr  (ram_addr[b]),
			.ram_wdata (ram_wdata[b]),
			.ram_we    (ram_we[b]),
			.ram_rdata (ram_rdata[b])
		);
	end

	read_return u_return (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.grant0       (grant[0]),
		.grant1       (grant[1]),
		.grant2       (grant[2]),
		.grant3       (grant[3]),
		.rdata0       (ram_rdata[0]),
		.rdata1       (ram_rdata[1]),
		.rdata2       (ram_rdata[2]),
		.rdata3       (ram_rdata[3]),
		.sprite_ready (sprite_ready),
		.bg_ready     (bg_ready),
		.flash_ready  (flash_ready),
		.cpu_ready    (cpu_ready),
		.sprite_rdata (sprite_rdata),
		.bg_rdata     (bg_rdata),
		.cpu_rdata    (cpu_rdata)
	);

endmodule

`default_nettype wire

// File: test/tb_shadow.svh
`ifndef TB_SHADOW_SVH
`define TB_SHADOW_SVH

// contents of every completed write, by full address
logic [data_w-1:0] shadow [1 << addr_w];
logic [addr_w-1:0] written [$];

// per requester results, indexed by req_id_t
int lat_of [5];
int done_of [5];
logic [data_w-1:0] data_of [5];

// edges between raising valid and the cycle ready is seen
task automatic wait_ready(input req_id_t who);
	lat_of[who] = 0;
	@(negedge CLK);
	while (!ready_now[who]) begin
		lat_of[who]++;
		@(negedge CLK);
	end
	done_of[who] = cycle;
endtask

task automatic sprite_read(input logic [addr_w-1:0] addr);
	sprite_addr = addr;
	sprite_valid = 1'b1;
	wait_ready(req_sprite);
	data_of[req_sprite] = sprite_rdata;
	@(posedge CLK);
	#1;
	sprite_valid = 1'b0;
endtask

task automatic bg_read(input logic [addr_w-1:0] addr);
	bg_addr = addr;
	bg_valid = 1'b1;
	wait_ready(req_bg);
	data_of[req_bg] = bg_rdata;
	@(posedge CLK);
	#1;
	bg_valid = 1'b0;
endtask

task automatic flash_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
	flash_addr = addr;
	flash_wdata = data;
	flash_valid = 1'b1;
	wait_ready(req_flash);
	shadow[addr] = data;
	written.push_back(addr);
	@(posedge CLK);
	#1;
	flash_valid = 1'b0;
endtask

task automatic cpu_access(input mem_op_t op, input logic [addr_w-1:0] addr,
		input logic [data_w-1:0] data);
	cpu_addr = addr;
	cpu_wdata = data;
	cpu_wr = (op == op_write);
	cpu_valid = 1'b1;
	wait_ready(req_cpu);
	if (op == op_write) begin
		shadow[addr] = data;
		written.push_back(addr);
	end else begin
		data_of[req_cpu] = cpu_rdata;
	end
	@(posedge CLK);
	#1;
	cpu_valid = 1'b0;
endtask

function automatic logic [data_w-1:0] expected_data(input logic [addr_w-1:0] addr);
	return shadow[addr];
endfunction

// any address already written in the given bank
function automatic logic [addr_w-1:0] pick_written(input int bank);
	logic [addr_w-1:0] hits [$];
	foreach (written[i]) begin
		if (written[i][addr_w-1:bank_addr_w] == 2'(bank)) begin
			hits.push_back(written[i]);
		end
	end
	return hits[$urandom_range(hits.size() - 1)];
endfunction

function automatic logic [addr_w-1:0] random_addr(input int bank);
	return {2'(bank), 14'($urandom())};
endfunction

`endif

// File: test/memory_arbiter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter_tb import vram_pkg::*; ();

	// about 200 transactions at 4 cycles each, plus margin
	localparam int max_cycles = 2000;

	logic CLK;
	logic RSTb;
	logic [addr_w-1:0] sprite_addr;
	logic sprite_valid;
	logic sprite_ready;
	logic [data_w-1:0] sprite_rdata;
	logic [addr_w-1:0] bg_addr;
	logic bg_valid;
	logic bg_ready;
	logic [data_w-1:0] bg_rdata;
	logic [addr_w-1:0] flash_addr;
	logic [data_w-1:0] flash_wdata;
	logic flash_valid;
	logic flash_ready;
	logic [addr_w-1:0] cpu_addr;
	logic [data_w-1:0] cpu_wdata;
	logic cpu_wr;
	logic cpu_valid;
	logic cpu_ready;
	logic [data_w-1:0] cpu_rdata;

	int mismatches = 0;
	int failures = 0;
	int cycle = 0;

	// bit positions follow req_id_t, bit 0 unused
	logic [4:0] ready_now;
	logic [4:0] valid_now;
	logic [4:0] ready_prev = '0;

	assign ready_now = {cpu_ready, flash_ready, bg_ready, sprite_ready, 1'b0};
	assign valid_now = {cpu_valid, flash_valid, bg_valid, sprite_valid, 1'b0};

`include "tb_shadow.svh"

	task automatic compare_value(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			mismatches++;
			$display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("error at cycle %0d: %s", cycle, what);
	endtask

	task automatic check_quiet();
		assert (ready_now == '0) else report_failure("ready high with no request pending");
		compare_value("sprite_rdata", 0, int'(sprite_rdata));
		compare_value("bg_rdata", 0, int'(bg_rdata));
		compare_value("cpu_rdata", 0, int'(cpu_rdata));
	endtask

	memory_arbiter uut (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.sprite_addr  (sprite_addr),
		.sprite_valid (sprite_valid),
		.sprite_ready (sprite_ready),
		.sprite_rdata (sprite_rdata),
		.bg_addr      (bg_addr),
		.bg_valid     (bg_valid),
		.bg_ready     (bg_ready),
		.bg_rdata     (bg_rdata),
		.flash_addr   (flash_addr),
		.flash_wdata  (flash_wdata),
		.flash_valid  (flash_valid),
		.flash_ready  (flash_ready),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_wr       (cpu_wr),
		.cpu_valid    (cpu_valid),
		.cpu_ready    (cpu_ready),
		.cpu_rdata    (cpu_rdata)
	);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle <= cycle + 1;
		if (cycle >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ready is a single-cycle pulse and only answers a pending request
	always @(negedge CLK) begin
		if (RSTb) begin
			assert ((ready_now & ready_prev) == '0)
				else report_failure("ready held high for more than one cycle");
			assert ((ready_now & ~valid_now) == '0)
				else report_failure("ready raised without a pending request");
		end
		ready_prev <= ready_now;
	end

	initial begin
		logic [addr_w-1:0] addr;
		logic [addr_w-1:0] addr2;
		logic [addr_w-1:0] f_addr;
		logic [addr_w-1:0] c_addr;
		logic [data_w-1:0] f_data;
		logic [data_w-1:0] c_data;
		logic [data_w-1:0] exp_s;
		logic [data_w-1:0] exp_b;

		void'($urandom(32'h69e1));
		RSTb = 1'b0;
		sprite_addr = '0;
		sprite_valid = 1'b0;
		bg_addr = '0;
		bg_valid = 1'b0;
		flash_addr = '0;
		flash_wdata = '0;
		flash_valid = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_wr = 1'b0;
		cpu_valid = 1'b0;

		// outputs quiet during reset and just after it
		@(posedge CLK);
		repeat (7) begin
			@(negedge CLK);
			check_quiet();
		end
		@(posedge CLK);
		#1;
		RSTb = 1'b1;
		repeat (2) begin
			@(negedge CLK);
			check_quiet();
		end
		@(posedge CLK);
		#1;

		// lone writes to every bank, each on a free bank
		for (int round = 0; round < 8; round++) begin
			for (int b = 0; b < num_banks; b++) begin
				flash_write(random_addr(b), 16'($urandom()));
				compare_value("flash_ready latency", 1, lat_of[req_flash]);
				cpu_access(op_write, random_addr(b), 16'($urandom()));
				compare_value("cpu_ready latency", 1, lat_of[req_cpu]);
			end
		end

		// read back through every read port
		for (int i = 0; i < 32; i++) begin
			addr = pick_written(i % num_banks);
			sprite_read(addr);
			compare_value("sprite_rdata", int'(expected_data(addr)), int'(data_of[req_sprite]));
			compare_value("sprite_ready latency", 1, lat_of[req_sprite]);
			addr = pick_written((i + 1) % num_banks);
			bg_read(addr);
			compare_value("bg_rdata", int'(expected_data(addr)), int'(data_of[req_bg]));
			compare_value("bg_ready latency", 1, lat_of[req_bg]);
			addr = pick_written((i + 2) % num_banks);
			cpu_access(op_read, addr, '0);
			compare_value("cpu_rdata", int'(expected_data(addr)), int'(data_of[req_cpu]));
			compare_value("cpu_ready latency", 1, lat_of[req_cpu]);
		end

		// all four on one bank in the same cycle
		for (int b = 0; b < num_banks; b++) begin
			addr = pick_written(b);
			addr2 = pick_written(b);
			exp_s = expected_data(addr);
			exp_b = expected_data(addr2);
			f_addr = random_addr(b);
			f_data = 16'($urandom());
			c_addr = random_addr(b);
			c_data = 16'($urandom());
			fork
				sprite_read(addr);
				bg_read(addr2);
				flash_write(f_addr, f_data);
				cpu_access(op_write, c_addr, c_data);
			join
			compare_value("sprite_rdata", int'(exp_s), int'(data_of[req_sprite]));
			compare_value("bg_rdata", int'(exp_b), int'(data_of[req_bg]));
			compare_value("sprite_ready latency", 1, lat_of[req_sprite]);
			assert (done_of[req_bg] - done_of[req_sprite] >= 2
					&& done_of[req_flash] - done_of[req_bg] >= 2
					&& done_of[req_cpu] - done_of[req_flash] >= 2)
				else report_failure("same-bank requests did not complete in priority order");
		end

		// one requester per bank, all in flight together
		for (int k = 0; k < num_banks; k++) begin
			addr = pick_written(k);
			addr2 = pick_written((k + 1) % num_banks);
			exp_s = expected_data(addr);
			exp_b = expected_data(addr2);
			f_addr = random_addr((k + 2) % num_banks);
			f_data = 16'($urandom());
			c_addr = random_addr((k + 3) % num_banks);
			c_data = 16'($urandom());
			fork
				sprite_read(addr);
				bg_read(addr2);
				flash_write(f_addr, f_data);
				cpu_access(op_write, c_addr, c_data);
			join
			compare_value("sprite_rdata", int'(exp_s), int'(data_of[req_sprite]));
			compare_value("bg_rdata", int'(exp_b), int'(data_of[req_bg]));
			compare_value("sprite_ready latency", 1, lat_of[req_sprite]);
			assert (done_of[req_bg] == done_of[req_sprite]
					&& done_of[req_flash] == done_of[req_sprite]
					&& done_of[req_cpu] == done_of[req_sprite])
				else report_failure("requests to different banks did not complete together");
		end

		// cpu write completion then read of the same word
		c_addr = random_addr(2);
		c_data = 16'($urandom());
		cpu_access(op_write, c_addr, c_data);
		compare_value("cpu_ready latency", 1, lat_of[req_cpu]);
		cpu_access(op_read, c_addr, '0);
		compare_value("cpu_rdata", int'(c_data), int'(data_of[req_cpu]));

		repeat (2) @(posedge CLK);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches + failures == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+test
verilog/vram_pkg.sv
verilog/bank_decode.sv
verilog/bank_arbiter.sv
verilog/bank_ram.sv
verilog/read_return.sv
verilog/memory_arbiter.sv
test/memory_arbiter_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module memory_arbiter_tb -f src.f -o sim \
	&& ./obj_dir/sim | tee /dev/stderr | grep -q "TEST PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
